/* test/ram_input_vectors.txt */
# tag | wr0: valid addr data en | wr1: valid addr data en | rd0: valid addr | rd1: valid addr
# then expected rd_data of read port 0 and read port 1, all hex, one cycle per line
# 1 reset clear
1  0 0 00000000 0  0 0 00000000 0  1 0  1 f  00000000 00000000
1  0 0 00000000 0  0 0 00000000 0  1 5  1 a  00000000 00000000
1  0 0 00000000 0  0 0 00000000 0  0 3  1 7  00000000 00000000
1  0 0 00000000 0  0 0 00000000 0  1 c  0 1  00000000 00000000

# 2 full write then read
2  1 3 11223344 f  0 0 00000000 0  1 4  1 2  00000000 00000000
2  0 0 00000000 0  0 0 00000000 0  1 3  1 3  11223344 11223344
2  0 0 00000000 0  1 9 a5a55a5a f  1 0  1 3  00000000 11223344
2  0 0 00000000 0  0 0 00000000 0  1 9  1 9  a5a55a5a a5a55a5a

# 3 partial write
3  1 3 deadbeef 5  0 0 00000000 0  1 9  1 1  a5a55a5a 00000000
3  0 0 00000000 0  1 9 0000ff00 2  1 3  1 0  11ad33ef 00000000
3  1 6 12345678 8  0 0 00000000 0  1 9  1 3  a5a5ff5a 11ad33ef
3  0 0 00000000 0  0 0 00000000 0  1 6  1 9  12000000 a5a5ff5a

# 4 dual write
4  1 1 cafef00d f  1 e 0badc0de f  1 2  1 d  00000000 00000000
4  1 2 01020304 3  1 d f0e0d0c0 c  1 1  1 e  cafef00d 0badc0de
4  0 0 00000000 0  0 0 00000000 0  1 2  1 d  00000304 f0e00000
4  1 1 00000000 1  1 e ffffffff 8  1 6  1 3  12000000 11ad33ef
4  0 0 00000000 0  0 0 00000000 0  1 1  1 e  cafef000 ffadc0de

# 5 bypass
5  1 4 55667788 f  0 0 00000000 0  1 4  1 5  55667788 00000000
5  1 4 aabbccdd 6  0 0 00000000 0  1 4  1 3  55bbcc88 11ad33ef
5  0 0 00000000 0  1 9 11111111 9  1 9  1 4  11a5ff11 55bbcc88
5  1 a 9999aaaa 1  1 b 12121212 2  1 b  1 a  00001200 000000aa
5  0 0 00000000 0  0 0 00000000 0  1 a  1 b  000000aa 00001200
5  1 6 00000000 0  0 0 00000000 0  1 6  1 9  12000000 11a5ff11

# 6 independent reads
6  0 0 00000000 0  0 0 00000000 0  1 3  0 4  11ad33ef 00000000
6  0 0 00000000 0  0 0 00000000 0  0 1  1 e  00000000 ffadc0de
6  0 0 00000000 0  0 0 00000000 0  1 9  1 2  11a5ff11 00000304
6  0 0 00000000 0  0 0 00000000 0  1 d  1 1  f0e00000 cafef000
6  0 0 00000000 0  0 0 00000000 0  0 4  0 6  00000000 00000000
6  0 0 00000000 0  0 0 00000000 0  1 4  1 6  55bbcc88 12000000

/* compile.f */
src/ram_geom_pkg.sv
src/ram_port_pkg.sv
src/ram_wr_if.sv
src/ram_write_decode.sv
src/ram_flop_array.sv
src/ram_read_port.sv
src/ram_flops_tile.sv
test/tb_ram_tile.sv

/* Makefile */
# Verilator build and run of the flop RAM tile testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ram_tile -Mdir obj_dir -f compile.f

# The run passes only if the log holds the pass message
run: compile
	./obj_dir/Vtb_ram_tile | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_ram_tile.sv */
//----------------------------------------
// RAM tile testbench
// Replays cycle vectors from a file and
// checks both read ports every cycle
//----------------------------------------

`timescale 1ns/1ps

module tb_ram_tile;

  //----------------------------------------
  // Run constants
  //----------------------------------------

  localparam int clk_period = 100;
  localparam int drive_delay = 10;
  localparam int reset_cycles = 8;
  localparam int max_vectors = 64;
  localparam int num_fields = 15;

  // Column positions within one vector line
  localparam int f_tag = 0;
  // Valid, address, data and word enable for each write port
  localparam int f_wr_base = 1;
  // Address valid and address for each read port
  localparam int f_rd_base = 9;
  // Expected rd_data for each read port
  localparam int f_exp_base = 13;

  //----------------------------------------
  // DUT signals
  //----------------------------------------

  logic wr_clk;
  logic wr_rst;
  logic [ram_geom_pkg::num_wr_ports-1:0] wr_valid;
  ram_port_pkg::ram_addr_t [ram_geom_pkg::num_wr_ports-1:0] wr_addr;
  ram_port_pkg::ram_data_t [ram_geom_pkg::num_wr_ports-1:0] wr_data;
  ram_port_pkg::ram_word_en_t [ram_geom_pkg::num_wr_ports-1:0] wr_word_en;
  logic [ram_geom_pkg::num_rd_ports-1:0] rd_addr_valid;
  ram_port_pkg::ram_addr_t [ram_geom_pkg::num_rd_ports-1:0] rd_addr;
  logic [ram_geom_pkg::num_rd_ports-1:0] rd_data_valid;
  ram_port_pkg::ram_data_t [ram_geom_pkg::num_rd_ports-1:0] rd_data;

  // Vector lines are read once before reset is released
  logic [31:0] vectors [max_vectors][num_fields];
  int num_vectors;
  logic vectors_loaded = 1'b0;

  // Counters shared by the check task and the main sequence
  int checks;
  int test_errors;

  ram_flops_tile ram_flops_tile_i (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_valid      (wr_valid),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_word_en    (wr_word_en),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  initial begin
    wr_clk = 1'b0;
    forever begin
      #(clk_period / 2) wr_clk = ~wr_clk;
    end
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------

  // The tag column of the vector file names the behavior under test
  function automatic string name_of_test(input logic [31:0] tag);
    case (tag)
      32'd1: return "reset_clear";
      32'd2: return "full_write";
      32'd3: return "partial_write";
      32'd4: return "dual_write";
      32'd5: return "bypass";
      32'd6: return "independent_reads";
      default: return "unknown";
    endcase
  endfunction

  task automatic load_vectors(output bit ok);
    int fd;
    int rc;
    string line;
    logic [31:0] f [num_fields];
    ok = 1'b0;
    num_vectors = 0;
    fd = $fopen("test/ram_input_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        // Blank lines and lines starting with # carry no vector
        if (rc > 1 && line[0] != "#") begin
          rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                       f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
          if (rc == num_fields && num_vectors < max_vectors) begin
            for (int k = 0; k < num_fields; k++) begin
              vectors[num_vectors][k] = f[k];
            end
            num_vectors++;
          end else begin
            $display("vector line could not be used: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
    if (num_vectors == 0) begin
      ok = 1'b0;
    end
  endtask

  // Puts one vector line on the write and read inputs
  task automatic apply_vector(input int i);
    for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
      wr_valid[p] = vectors[i][f_wr_base + 4 * p][0];
      wr_addr[p] = ram_port_pkg::ram_addr_t'(vectors[i][f_wr_base + 4 * p + 1]);
      // An idle port carries all-ones data on every lane so a write that
      // ignores valid would corrupt the addressed row where a read sees it
      if (wr_valid[p]) begin
        wr_data[p] = vectors[i][f_wr_base + 4 * p + 2];
        wr_word_en[p] = ram_port_pkg::ram_word_en_t'(vectors[i][f_wr_base + 4 * p + 3]);
      end else begin
        wr_data[p] = '1;
        wr_word_en[p] = '1;
      end
    end
    for (int r = 0; r < ram_geom_pkg::num_rd_ports; r++) begin
      rd_addr_valid[r] = vectors[i][f_rd_base + 2 * r][0];
      rd_addr[r] = ram_port_pkg::ram_addr_t'(vectors[i][f_rd_base + 2 * r + 1]);
    end
  endtask

  // Compares both read ports with the expected columns of one line
  task automatic check_vector(input int i);
    string name;
    logic exp_valid;
    ram_port_pkg::ram_data_t exp_data;
    name = name_of_test(vectors[i][f_tag]);
    for (int r = 0; r < ram_geom_pkg::num_rd_ports; r++) begin
      exp_valid = vectors[i][f_rd_base + 2 * r][0];
      exp_data = vectors[i][f_exp_base + r];
      checks++;
      assert (rd_data_valid[r] === exp_valid) else begin
        $display("FAIL %s line %0d rd_data_valid[%0d] expected %b actual %b",
                 name, i, r, exp_valid, rd_data_valid[r]);
        test_errors++;
      end
      // Read data only means something while the address is valid
      if (exp_valid) begin
        checks++;
        assert (rd_data[r] === exp_data) else begin
          $display("FAIL %s line %0d rd_data[%0d] expected %h actual %h",
                   name, i, r, exp_data, rd_data[r]);
          test_errors++;
        end
      end
    end
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial begin : main
    bit load_ok;
    int test_cycles;
    int tests_run;
    int tests_bad;
    int total_errors;
    wr_rst = 1'b1;
    wr_valid = '0;
    wr_addr = '0;
    wr_data = '0;
    wr_word_en = '0;
    rd_addr_valid = '0;
    rd_addr = '0;
    checks = 0;
    test_errors = 0;
    test_cycles = 0;
    tests_run = 0;
    tests_bad = 0;
    total_errors = 0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("the vector file test/ram_input_vectors.txt could not be read");
      $display("tests failed");
      $finish;
    end else begin
      vectors_loaded = 1'b1;
      repeat (reset_cycles) @(posedge wr_clk);
      #(drive_delay);
      wr_rst = 1'b0;
      for (int i = 0; i < num_vectors; i++) begin
        if (i > 0) begin
          @(posedge wr_clk);
          #(drive_delay);
        end
        apply_vector(i);
        // Reads are combinational, so they have settled well before the next edge
        #(clk_period - 2 * drive_delay);
        check_vector(i);
        test_cycles++;
        // A test ends where the tag changes or the file runs out
        if (i == num_vectors - 1 || vectors[i + 1][f_tag] != vectors[i][f_tag]) begin
          $display("test %-18s %0d cycles, %0d errors",
                   name_of_test(vectors[i][f_tag]), test_cycles, test_errors);
          tests_run++;
          if (test_errors != 0) begin
            tests_bad++;
          end
          total_errors += test_errors;
          test_errors = 0;
          test_cycles = 0;
        end
      end
      $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_bad, checks, total_errors);
      if (total_errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

  // Each vector needs one cycle, so twice that plus reset leaves ample margin
  initial begin : watchdog
    wait (vectors_loaded);
    #(num_vectors * 2 * clk_period + reset_cycles * clk_period);
    $display("timeout: the vector run did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule : tb_ram_tile

/* src/ram_flops_tile.sv */
//----------------------------------------
// Flop RAM tile
// 16 x 32 bit RAM with two byte-enabled
// write ports and two bypassing read ports
//----------------------------------------

`timescale 1ns/1ps

module ram_flops_tile (
  input  logic wr_clk,
  input  logic wr_rst,

  // Write ports
  input  logic [ram_geom_pkg::num_wr_ports-1:0] wr_valid,
  input  ram_port_pkg::ram_addr_t [ram_geom_pkg::num_wr_ports-1:0] wr_addr,
  input  ram_port_pkg::ram_data_t [ram_geom_pkg::num_wr_ports-1:0] wr_data,
  input  ram_port_pkg::ram_word_en_t [ram_geom_pkg::num_wr_ports-1:0] wr_word_en,

  // Read ports
  input  logic [ram_geom_pkg::num_rd_ports-1:0] rd_addr_valid,
  input  ram_port_pkg::ram_addr_t [ram_geom_pkg::num_rd_ports-1:0] rd_addr,
  output logic [ram_geom_pkg::num_rd_ports-1:0] rd_data_valid,
  output ram_port_pkg::ram_data_t [ram_geom_pkg::num_rd_ports-1:0] rd_data
);

  //----------------------------------------
  // Write bus
  //----------------------------------------

  // The tile's own ports act as the source side of the write bus
  ram_wr_if wr_bus ();

  assign wr_bus.wr_valid = wr_valid;
  assign wr_bus.wr_addr = wr_addr;
  assign wr_bus.wr_data = wr_data;
  assign wr_bus.wr_word_en = wr_word_en;

  //----------------------------------------
  // Write path and storage
  //----------------------------------------

  ram_port_pkg::ram_word_en_t [ram_geom_pkg::ram_depth-1:0] row_load;
  ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] row_data;
  ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] mem_rows;

  ram_write_decode write_decode_i (
    .wr       (wr_bus.sink),
    .row_load (row_load),
    .row_data (row_data)
  );

  // Writes become visible in mem_rows one cycle after they are presented
  ram_flop_array flop_array_i (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .row_load (row_load),
    .row_data (row_data),
    .mem_rows (mem_rows)
  );

  //----------------------------------------
  // Read ports
  //----------------------------------------

  // Reads have no latency, so valid is just passed across
  assign rd_data_valid = rd_addr_valid;

  for (genvar i = 0; i < ram_geom_pkg::num_rd_ports; i++) begin : gen_rd_port
    ram_read_port read_port_i (
      .wr       (wr_bus.sink),
      .rd_addr  (rd_addr[i]),
      .mem_rows (mem_rows),
      .rd_data  (rd_data[i])
    );
  end

endmodule : ram_flops_tile

/* src/ram_read_port.sv */
//----------------------------------------
// RAM read port
// Combinational row mux with byte-wise
// bypass of writes in the same cycle
//----------------------------------------

`timescale 1ns/1ps

module ram_read_port (
  ram_wr_if.sink wr,
  input  ram_port_pkg::ram_addr_t rd_addr,
  input  ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] mem_rows,
  output ram_port_pkg::ram_data_t rd_data
);

  //----------------------------------------
  // Stored row
  //----------------------------------------

  // Value held in the flops for the addressed row
  ram_port_pkg::ram_data_t stored_row;

  assign stored_row = mem_rows[rd_addr];

  //----------------------------------------
  // Bypass select
  //----------------------------------------

  // Ports whose valid write targets the row being read
  logic [ram_geom_pkg::num_wr_ports-1:0] wr_match;

  // Data and lane enables of the matching port, zero if none matches
  ram_port_pkg::ram_data_t bypass_data;
  ram_port_pkg::ram_word_en_t bypass_en;

  always_comb begin
    for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
      wr_match[p] = wr.wr_valid[p] && (wr.wr_addr[p] == rd_addr);
    end
  end

  // At most one port can match, since two writes never share a row
  always_comb begin
    bypass_data = '0;
    bypass_en = '0;
    for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
      bypass_data = bypass_data | ({ram_geom_pkg::data_width{wr_match[p]}} & wr.wr_data[p]);
      bypass_en = bypass_en | ({ram_geom_pkg::num_words{wr_match[p]}} & wr.wr_word_en[p]);
    end
  end

  //----------------------------------------
  // Lane merge
  //----------------------------------------

  // New byte where the matching write enables the lane, stored byte elsewhere.
  // With no match bypass_en is zero and the stored row passes unchanged
  always_comb begin
    for (int w = 0; w < ram_geom_pkg::num_words; w++) begin
      if (bypass_en[w]) begin
        rd_data[w*ram_geom_pkg::word_width +: ram_geom_pkg::word_width] =
            bypass_data[w*ram_geom_pkg::word_width +: ram_geom_pkg::word_width];
      end else begin
        rd_data[w*ram_geom_pkg::word_width +: ram_geom_pkg::word_width] =
            stored_row[w*ram_geom_pkg::word_width +: ram_geom_pkg::word_width];
      end
    end
  end

endmodule : ram_read_port

/* src/ram_flop_array.sv */
//----------------------------------------
// RAM flop array
// Row storage as byte-lane flops with a
// synchronous clear and per-lane loads
//----------------------------------------

`timescale 1ns/1ps

module ram_flop_array (
  input  logic wr_clk,
  input  logic wr_rst,
  input  ram_port_pkg::ram_word_en_t [ram_geom_pkg::ram_depth-1:0] row_load,
  input  ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] row_data,
  output ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] mem_rows
);

  // Every lane of every row is its own small register
  for (genvar r = 0; r < ram_geom_pkg::ram_depth; r++) begin : gen_row
    ram_port_pkg::ram_word_t [ram_geom_pkg::num_words-1:0] lanes_q;

    for (genvar w = 0; w < ram_geom_pkg::num_words; w++) begin : gen_lane
      // Byte of the incoming row that belongs to this lane
      ram_port_pkg::ram_word_t lane_d;

      assign lane_d = row_data[r][w*ram_geom_pkg::word_width +: ram_geom_pkg::word_width];

      always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
          // Clear the whole tile while reset is held
          lanes_q[w] <= '0;
        end else if (row_load[r][w]) begin
          lanes_q[w] <= lane_d;
        end
      end
    end

    // Stored row goes out flat to the read ports
    assign mem_rows[r] = lanes_q;
  end

endmodule : ram_flop_array

/* src/ram_write_decode.sv */
//----------------------------------------
// RAM write decode
// Turns write addresses into per-row lane
// loads and picks each row's write data
//----------------------------------------

`timescale 1ns/1ps

module ram_write_decode (
  ram_wr_if.sink wr,
  output ram_port_pkg::ram_word_en_t [ram_geom_pkg::ram_depth-1:0] row_load,
  output ram_port_pkg::ram_data_t [ram_geom_pkg::ram_depth-1:0] row_data
);

  //----------------------------------------
  // Address decode
  //----------------------------------------

  // One-hot row select per write port, all zero when the port is idle
  ram_port_pkg::ram_row_mask_t [ram_geom_pkg::num_wr_ports-1:0] port_row_mask;

  // Same bits regrouped by row, so each row sees which ports hit it
  logic [ram_geom_pkg::ram_depth-1:0][ram_geom_pkg::num_wr_ports-1:0] row_port_hit;

  always_comb begin
    for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
      if (wr.wr_valid[p]) begin
        port_row_mask[p] = ram_port_pkg::ram_row_mask_t'(1) << wr.wr_addr[p];
      end else begin
        port_row_mask[p] = '0;
      end
    end
  end

  // Transpose from port-major to row-major
  always_comb begin
    for (int r = 0; r < ram_geom_pkg::ram_depth; r++) begin
      for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
        row_port_hit[r][p] = port_row_mask[p][r];
      end
    end
  end

  //----------------------------------------
  // Per-row select
  //----------------------------------------

  // Writes to the same row from two ports never happen together, so the
  // hit vector of a row is one-hot or zero and an AND-OR mux is enough.
  // A row with no hit ends up with zero loads and zero data
  always_comb begin
    for (int r = 0; r < ram_geom_pkg::ram_depth; r++) begin
      row_load[r] = '0;
      row_data[r] = '0;
      for (int p = 0; p < ram_geom_pkg::num_wr_ports; p++) begin
        // Lane loads come straight from the hitting port's word enable
        row_load[r] = row_load[r] |
                      ({ram_geom_pkg::num_words{row_port_hit[r][p]}} & wr.wr_word_en[p]);
        row_data[r] = row_data[r] |
                      ({ram_geom_pkg::data_width{row_port_hit[r][p]}} & wr.wr_data[p]);
      end
    end
  end

endmodule : ram_write_decode

/* src/ram_wr_if.sv */
//----------------------------------------
// RAM write bus
// Groups the signals of every write port
//----------------------------------------

`timescale 1ns/1ps

interface ram_wr_if;

  // Each array below is indexed by write port number

  // A port only writes when its valid bit is high
  logic [ram_geom_pkg::num_wr_ports-1:0] wr_valid;

  // Target row of each port
  ram_port_pkg::ram_addr_t [ram_geom_pkg::num_wr_ports-1:0] wr_addr;

  // Full row of write data per port, only enabled lanes are stored
  ram_port_pkg::ram_data_t [ram_geom_pkg::num_wr_ports-1:0] wr_data;

  // Lane enables per port
  ram_port_pkg::ram_word_en_t [ram_geom_pkg::num_wr_ports-1:0] wr_word_en;

  //----------------------------------------
  // Modports
  //----------------------------------------

  // The side that presents write requests
  modport src (output wr_valid, output wr_addr, output wr_data, output wr_word_en);

  // Decode logic and bypass paths only observe the requests
  modport sink (input wr_valid, input wr_addr, input wr_data, input wr_word_en);

endinterface : ram_wr_if

/* src/ram_port_pkg.sv */
//----------------------------------------
// RAM tile port types
// Vector types for the values that travel
// on the write, read and row-level ports
//----------------------------------------

package ram_port_pkg;

  //----------------------------------------
  // Address and data
  //----------------------------------------

  // Row address, shared by write and read ports
  typedef logic [ram_geom_pkg::addr_width-1:0] ram_addr_t;

  // One full row of data
  typedef logic [ram_geom_pkg::data_width-1:0] ram_data_t;

  // One byte lane of a row
  typedef logic [ram_geom_pkg::word_width-1:0] ram_word_t;

  //----------------------------------------
  // Masks
  //----------------------------------------

  // Per-lane write mask, bit i covers bits [i*8 +: 8] of a row
  typedef logic [ram_geom_pkg::num_words-1:0] ram_word_en_t;

  // One bit per row, used for the one-hot decode of a write address
  typedef logic [ram_geom_pkg::ram_depth-1:0] ram_row_mask_t;

endpackage : ram_port_pkg

/* src/ram_geom_pkg.sv */
//----------------------------------------
// RAM tile geometry
// Fixed depth, row width, byte lane width
// and port counts of the flop RAM tile
//----------------------------------------

package ram_geom_pkg;

  //----------------------------------------
  // Storage shape
  //----------------------------------------

  // Number of rows held in the tile
  localparam int ram_depth = 16;

  // Bits stored in one row
  localparam int data_width = 32;

  // Bits in one byte lane, the smallest unit a write can change
  localparam int word_width = 8;

  // Byte lanes per row, so one word enable bit per lane
  localparam int num_words = data_width / word_width;

  // Bits needed to address one row
  localparam int addr_width = $clog2(ram_depth);

  //----------------------------------------
  // Port counts
  //----------------------------------------

  // Both write ports land on the same clock edge
  localparam int num_wr_ports = 2;

  // Read ports are independent combinational paths
  localparam int num_rd_ports = 2;

endpackage : ram_geom_pkg
